/* source/radio_consts.svh */
`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

//////////////////////////////
// Datapath and bus widths
//////////////////////////////
`define RADIO_NUM_CHAN    2      // Radio channels in the core
`define RADIO_SAMPLE_W    16     // One I or Q sample
`define RADIO_SET_ADDR_W  8      // Settings bus address
`define RADIO_SET_DATA_W  32     // Settings bus data

//////////////////////////////
// Register windows
//////////////////////////////
`define TX_FE_BASE        224    // TX correction window
`define RX_FE_BASE        232    // RX correction window

`define FE_REG_OFFSET_I   0      // Signed DC offset for I
`define FE_REG_OFFSET_Q   1      // Signed DC offset for Q
`define FE_REG_MAP        2      // Swap and invert bits

// Clocks from input valid to output valid
`define FE_LATENCY        2

`endif

/* source/radio_setting_pkg.sv */
`include "radio_consts.svh"

package radio_setting_pkg;

   //////////////////////////////
   // Settings bus
   //////////////////////////////

   // One write per clock, no handshake
   typedef struct packed {
      logic                         stb;    // Write strobe
      logic [`RADIO_SET_ADDR_W-1:0] addr;   // Register address
      logic [`RADIO_SET_DATA_W-1:0] data;   // Write data
   } set_bus_t;

   //////////////////////////////
   // Mapping register fields
   //////////////////////////////

   // Matches data[1:0] of the write
   typedef struct packed {
      logic invert_q;   // Bit 1, negate Q
      logic swap_iq;    // Bit 0, exchange I and Q
   } iq_map_t;

endpackage

/* source/radio_sample_pkg.sv */
`include "radio_consts.svh"

package radio_sample_pkg;

   typedef logic signed [`RADIO_SAMPLE_W-1:0] sample_t;   // Two's complement

   typedef struct packed {
      sample_t i;   // Upper half of the word
      sample_t q;   // Lower half of the word
   } iq_pair_t;

   // Same 32 bits, converter view or I/Q view
   typedef union packed {
      logic [2*`RADIO_SAMPLE_W-1:0] raw;   // As the converter sees it
      iq_pair_t                     iq;    // Split into I and Q
   } iq_word_u;

   localparam sample_t SAMPLE_MAX = {1'b0, {(`RADIO_SAMPLE_W-1){1'b1}}};   // 32767
   localparam sample_t SAMPLE_MIN = {1'b1, {(`RADIO_SAMPLE_W-1){1'b0}}};   // -32768

   // Add with clamp to the sample range
   function automatic sample_t sat_add(sample_t a, sample_t b);
      logic signed [`RADIO_SAMPLE_W:0] sum;   // One guard bit
      sum = a + b;
      if (sum[`RADIO_SAMPLE_W] != sum[`RADIO_SAMPLE_W-1])   // Overflow
         return sum[`RADIO_SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;
      return sample_t'(sum[`RADIO_SAMPLE_W-1:0]);
   endfunction

   // Negate, most negative value clamps to max
   function automatic sample_t sat_neg(sample_t a);
      if (a == SAMPLE_MIN)
         return SAMPLE_MAX;
      return -a;
   endfunction

endpackage

/* source/rx_frontend.sv */
`timescale 1ns/1ps
`include "radio_consts.svh"

module rx_frontend
   import radio_setting_pkg::*, radio_sample_pkg::*;
(
   input  logic     radio_clk,
   input  logic     reset_i,     // Sync, active high
   input  set_bus_t set_bus_i,   // Shared with the TX block
   input  iq_word_u adc_word_i,  // Raw converter word
   input  logic     adc_valid_i,
   output iq_word_u rx_word_o,   // Corrected word
   output logic     rx_valid_o
);

   //////////////////////////////
   // Register window
   //////////////////////////////

   localparam logic [`RADIO_SET_ADDR_W-1:0] ADDR_OFFSET_I = `RX_FE_BASE + `FE_REG_OFFSET_I;
   localparam logic [`RADIO_SET_ADDR_W-1:0] ADDR_OFFSET_Q = `RX_FE_BASE + `FE_REG_OFFSET_Q;
   localparam logic [`RADIO_SET_ADDR_W-1:0] ADDR_MAP      = `RX_FE_BASE + `FE_REG_MAP;

   sample_t  offset_i;   // DC offset added to I
   sample_t  offset_q;   // DC offset added to Q
   iq_map_t  iq_map;     // Swap and invert control

   iq_word_u mapped;     // Stage 1 input after mapping
   iq_word_u s1_word;    // Mapped sample
   sample_t  s1_off_i;   // Offsets that belong to this sample
   sample_t  s1_off_q;
   logic     s1_valid;

   always_ff @(posedge radio_clk) begin : set_regs
      if (reset_i) begin
         offset_i <= '0;
         offset_q <= '0;
         iq_map   <= '0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            ADDR_OFFSET_I: offset_i <= sample_t'(set_bus_i.data[`RADIO_SAMPLE_W-1:0]);
            ADDR_OFFSET_Q: offset_q <= sample_t'(set_bus_i.data[`RADIO_SAMPLE_W-1:0]);
            ADDR_MAP:      iq_map   <= iq_map_t'(set_bus_i.data[$bits(iq_map_t)-1:0]);
            default: ;     // Not in the RX window
         endcase
      end
   end

   //////////////////////////////
   // Stage 1, I/Q mapping
   //////////////////////////////

   always_comb begin : map_comb
      mapped.raw = adc_word_i.raw;          // Straight through by default
      if (iq_map.swap_iq) begin
         mapped.iq.i = adc_word_i.iq.q;
         mapped.iq.q = adc_word_i.iq.i;
      end
      if (iq_map.invert_q) begin
         mapped.iq.q = sat_neg(mapped.iq.q);   // -32768 gives 32767
      end
   end

   // Offsets ride along so a write lands on whole samples only
   always_ff @(posedge radio_clk) begin : stage1
      if (reset_i) begin
         s1_word  <= '0;
         s1_off_i <= '0;
         s1_off_q <= '0;
         s1_valid <= 1'b0;
      end else begin
         s1_word  <= mapped;
         s1_off_i <= offset_i;
         s1_off_q <= offset_q;
         s1_valid <= adc_valid_i;
      end
   end

   //////////////////////////////
   // Stage 2, DC offset
   //////////////////////////////

   always_ff @(posedge radio_clk) begin : stage2
      if (reset_i) begin
         rx_word_o  <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         rx_word_o.iq.i <= sat_add(s1_word.iq.i, s1_off_i);   // Clamped
         rx_word_o.iq.q <= sat_add(s1_word.iq.q, s1_off_q);
         rx_valid_o     <= s1_valid;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Fixed latency, no gaps filled or samples lost
   a_rx_latency: assert property (
      @(posedge radio_clk) disable iff (reset_i)
      rx_valid_o == $past(adc_valid_i, `FE_LATENCY)
   ) else $error("rx_frontend valid out of step with adc_valid_i");

endmodule

/* source/tx_frontend.sv */
`timescale 1ns/1ps
`include "radio_consts.svh"

module tx_frontend
   import radio_setting_pkg::*, radio_sample_pkg::*;
(
   input  logic     radio_clk,
   input  logic     reset_i,     // Sync, active high
   input  set_bus_t set_bus_i,   // Shared with the RX block
   input  iq_word_u tx_word_i,   // Sample to transmit
   input  logic     tx_valid_i,
   output iq_word_u dac_word_o,  // Word for the DAC
   output logic     dac_valid_o
);

   //////////////////////////////
   // Register window
   //////////////////////////////

   localparam logic [`RADIO_SET_ADDR_W-1:0] ADDR_OFFSET_I = `TX_FE_BASE + `FE_REG_OFFSET_I;
   localparam logic [`RADIO_SET_ADDR_W-1:0] ADDR_OFFSET_Q = `TX_FE_BASE + `FE_REG_OFFSET_Q;
   localparam logic [`RADIO_SET_ADDR_W-1:0] ADDR_MUX      = `TX_FE_BASE + `FE_REG_MAP;

   sample_t  offset_i;   // DC offset added to I
   sample_t  offset_q;   // DC offset added to Q
   iq_map_t  mux;        // Only swap_iq acts here

   iq_word_u s1_word;    // Offset-corrected sample
   logic     s1_swap;    // Swap bit seen by this sample
   logic     s1_valid;

   always_ff @(posedge radio_clk) begin : set_regs
      if (reset_i) begin
         offset_i <= '0;
         offset_q <= '0;
         mux      <= '0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            ADDR_OFFSET_I: offset_i <= sample_t'(set_bus_i.data[`RADIO_SAMPLE_W-1:0]);
            ADDR_OFFSET_Q: offset_q <= sample_t'(set_bus_i.data[`RADIO_SAMPLE_W-1:0]);
            ADDR_MUX:      mux      <= iq_map_t'(set_bus_i.data[$bits(iq_map_t)-1:0]);
            default: ;     // Not in the TX window
         endcase
      end
   end

   //////////////////////////////
   // Stage 1, DC offset
   //////////////////////////////

   always_ff @(posedge radio_clk) begin : stage1
      if (reset_i) begin
         s1_word  <= '0;
         s1_swap  <= 1'b0;
         s1_valid <= 1'b0;
      end else begin
         s1_word.iq.i <= sat_add(tx_word_i.iq.i, offset_i);   // Clamped
         s1_word.iq.q <= sat_add(tx_word_i.iq.q, offset_q);
         s1_swap      <= mux.swap_iq;   // Sampled with the data
         s1_valid     <= tx_valid_i;
      end
   end

   //////////////////////////////
   // Stage 2, I/Q swap
   //////////////////////////////

   // Swap after the add, so a clamped I can land in the Q half
   always_ff @(posedge radio_clk) begin : stage2
      if (reset_i) begin
         dac_word_o  <= '0;
         dac_valid_o <= 1'b0;
      end else begin
         if (s1_swap) begin
            dac_word_o.iq.i <= s1_word.iq.q;
            dac_word_o.iq.q <= s1_word.iq.i;
         end else begin
            dac_word_o.raw <= s1_word.raw;   // Word as is
         end
         dac_valid_o <= s1_valid;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   a_tx_latency: assert property (
      @(posedge radio_clk) disable iff (reset_i)
      dac_valid_o == $past(tx_valid_i, `FE_LATENCY)
   ) else $error("tx_frontend valid out of step with tx_valid_i");

   // Both windows decode this address, an X would corrupt either block
   a_set_addr_known: assert property (
      @(posedge radio_clk) disable iff (reset_i)
      set_bus_i.stb |-> !$isunknown(set_bus_i.addr)
   ) else $error("settings address unknown while strobe is high");

endmodule

/* source/radio_frontend_top.sv */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_frontend_top
   import radio_setting_pkg::*, radio_sample_pkg::*;
(
   input  logic     radio_clk,
   input  logic     reset_i,                         // Sync, active high

   // Settings, one bus per channel
   input  set_bus_t set_bus_i   [`RADIO_NUM_CHAN],

   // Receive side
   input  iq_word_u adc_word_i  [`RADIO_NUM_CHAN],   // From the ADC
   input  logic     adc_valid_i [`RADIO_NUM_CHAN],
   output iq_word_u rx_word_o   [`RADIO_NUM_CHAN],   // Corrected RX
   output logic     rx_valid_o  [`RADIO_NUM_CHAN],

   // Transmit side
   input  iq_word_u tx_word_i   [`RADIO_NUM_CHAN],   // Samples to send
   input  logic     tx_valid_i  [`RADIO_NUM_CHAN],
   output iq_word_u dac_word_o  [`RADIO_NUM_CHAN],   // To the DAC
   output logic     dac_valid_o [`RADIO_NUM_CHAN]
);

   //////////////////////////////
   // Per-channel front ends
   //////////////////////////////

   // Both blocks of a channel see the same bus and pick their own window
   for (genvar ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin : g_chan

      rx_frontend rx_frontend_inst (
         .radio_clk   (radio_clk),
         .reset_i     (reset_i),
         .set_bus_i   (set_bus_i[ch]),      // Window at 232
         .adc_word_i  (adc_word_i[ch]),
         .adc_valid_i (adc_valid_i[ch]),
         .rx_word_o   (rx_word_o[ch]),
         .rx_valid_o  (rx_valid_o[ch])
      );

      tx_frontend tx_frontend_inst (
         .radio_clk   (radio_clk),
         .reset_i     (reset_i),
         .set_bus_i   (set_bus_i[ch]),      // Window at 224
         .tx_word_i   (tx_word_i[ch]),
         .tx_valid_i  (tx_valid_i[ch]),
         .dac_word_o  (dac_word_o[ch]),
         .dac_valid_o (dac_valid_o[ch])
      );

   end

endmodule

/* verification/radio_frontend_checks.sv */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_frontend_checks
   import radio_setting_pkg::*, radio_sample_pkg::*;
(
   input  logic     radio_clk,
   input  logic     reset_i,
   input  set_bus_t set_bus_i   [`RADIO_NUM_CHAN],
   input  iq_word_u adc_word_i  [`RADIO_NUM_CHAN],
   input  logic     adc_valid_i [`RADIO_NUM_CHAN],
   input  iq_word_u tx_word_i   [`RADIO_NUM_CHAN],
   input  logic     tx_valid_i  [`RADIO_NUM_CHAN],
   input  iq_word_u rx_word_i   [`RADIO_NUM_CHAN],   // Observed DUT outputs
   input  logic     rx_valid_i  [`RADIO_NUM_CHAN],
   input  iq_word_u dac_word_i  [`RADIO_NUM_CHAN],
   input  logic     dac_valid_i [`RADIO_NUM_CHAN],
   output int       value_errors_o,
   output int       valid_errors_o
);

   sample_t     rx_off_i  [`RADIO_NUM_CHAN];   // Model copies of the registers
   sample_t     rx_off_q  [`RADIO_NUM_CHAN];
   iq_map_t     rx_map    [`RADIO_NUM_CHAN];
   sample_t     tx_off_i  [`RADIO_NUM_CHAN];
   sample_t     tx_off_q  [`RADIO_NUM_CHAN];
   iq_map_t     tx_mux    [`RADIO_NUM_CHAN];
   logic [31:0] rx_exp_d1 [`RADIO_NUM_CHAN];   // Expected words, two stages
   logic [31:0] rx_exp_d2 [`RADIO_NUM_CHAN];
   logic [31:0] tx_exp_d1 [`RADIO_NUM_CHAN];
   logic [31:0] tx_exp_d2 [`RADIO_NUM_CHAN];
   logic        rx_vld_d1 [`RADIO_NUM_CHAN];
   logic        rx_vld_d2 [`RADIO_NUM_CHAN];
   logic        tx_vld_d1 [`RADIO_NUM_CHAN];
   logic        tx_vld_d2 [`RADIO_NUM_CHAN];
   int          err_cnt   [`RADIO_NUM_CHAN][4] = '{default: 0};   // RX val, TX val, RX vld, TX vld

   ///////////////////////////////
   // Reference arithmetic
   ///////////////////////////////

   function automatic sample_t clamp(input int v);
      if (v > 32767)
         return 16'sh7fff;
      if (v < -32768)
         return 16'sh8000;
      return sample_t'(v);
   endfunction

   // Map first, offset second
   function automatic logic [31:0] rx_expect(input iq_word_u w, input sample_t oi,
                                             input sample_t oq, input iq_map_t m);
      int i;
      int q;
      int t;
      i = int'(w.iq.i);
      q = int'(w.iq.q);
      if (m.swap_iq) begin
         t = i;
         i = q;
         q = t;
      end
      if (m.invert_q)
         q = int'(clamp(-q));   // -32768 turns into 32767
      return {clamp(i + int'(oi)), clamp(q + int'(oq))};
   endfunction

   // Offset first, swap second
   function automatic logic [31:0] tx_expect(input iq_word_u w, input sample_t oi,
                                             input sample_t oq, input logic swap);
      sample_t i;
      sample_t q;
      i = clamp(int'(w.iq.i) + int'(oi));
      q = clamp(int'(w.iq.q) + int'(oq));
      return swap ? {q, i} : {i, q};
   endfunction

   always_ff @(posedge radio_clk) begin : model
      for (int ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin
         if (reset_i) begin
            rx_off_i[ch]  <= '0;
            rx_off_q[ch]  <= '0;
            rx_map[ch]    <= '0;
            tx_off_i[ch]  <= '0;
            tx_off_q[ch]  <= '0;
            tx_mux[ch]    <= '0;
            rx_exp_d1[ch] <= '0;
            rx_exp_d2[ch] <= '0;
            tx_exp_d1[ch] <= '0;
            tx_exp_d2[ch] <= '0;
            rx_vld_d1[ch] <= 1'b0;
            rx_vld_d2[ch] <= 1'b0;
            tx_vld_d1[ch] <= 1'b0;
            tx_vld_d2[ch] <= 1'b0;
         end else begin
            // Register values before this clock's write
            rx_exp_d1[ch] <= rx_expect(adc_word_i[ch], rx_off_i[ch], rx_off_q[ch], rx_map[ch]);
            tx_exp_d1[ch] <= tx_expect(tx_word_i[ch], tx_off_i[ch], tx_off_q[ch],
                                       tx_mux[ch].swap_iq);
            rx_exp_d2[ch] <= rx_exp_d1[ch];
            tx_exp_d2[ch] <= tx_exp_d1[ch];
            rx_vld_d1[ch] <= adc_valid_i[ch];
            rx_vld_d2[ch] <= rx_vld_d1[ch];
            tx_vld_d1[ch] <= tx_valid_i[ch];
            tx_vld_d2[ch] <= tx_vld_d1[ch];
            if (set_bus_i[ch].stb) begin
               case (set_bus_i[ch].addr)
                  8'd232:  rx_off_i[ch] <= sample_t'(set_bus_i[ch].data[15:0]);
                  8'd233:  rx_off_q[ch] <= sample_t'(set_bus_i[ch].data[15:0]);
                  8'd234:  rx_map[ch]   <= iq_map_t'(set_bus_i[ch].data[1:0]);
                  8'd224:  tx_off_i[ch] <= sample_t'(set_bus_i[ch].data[15:0]);
                  8'd225:  tx_off_q[ch] <= sample_t'(set_bus_i[ch].data[15:0]);
                  8'd226:  tx_mux[ch]   <= iq_map_t'(set_bus_i[ch].data[1:0]);
                  default: ;   // Outside both windows
               endcase
            end
         end
      end
   end

   ///////////////////////////////
   // Output checks
   ///////////////////////////////

   for (genvar ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin : g_chk

      a_rx_word: assert property (@(posedge radio_clk) disable iff (reset_i)
         rx_vld_d2[ch] |-> rx_word_i[ch].raw == rx_exp_d2[ch])
      else begin
         err_cnt[ch][0]++;
         $display("FAILED t=%0t rx_word_o[%0d] expected %h got %h", $time, ch,
                  $sampled(rx_exp_d2[ch]), $sampled(rx_word_i[ch].raw));
      end

      a_dac_word: assert property (@(posedge radio_clk) disable iff (reset_i)
         tx_vld_d2[ch] |-> dac_word_i[ch].raw == tx_exp_d2[ch])
      else begin
         err_cnt[ch][1]++;
         $display("FAILED t=%0t dac_word_o[%0d] expected %h got %h", $time, ch,
                  $sampled(tx_exp_d2[ch]), $sampled(dac_word_i[ch].raw));
      end

      a_rx_valid: assert property (@(posedge radio_clk) disable iff (reset_i)
         rx_valid_i[ch] == rx_vld_d2[ch])
      else begin
         err_cnt[ch][2]++;
         $display("FAILED t=%0t rx_valid_o[%0d] expected %b got %b", $time, ch,
                  $sampled(rx_vld_d2[ch]), $sampled(rx_valid_i[ch]));
      end

      a_dac_valid: assert property (@(posedge radio_clk) disable iff (reset_i)
         dac_valid_i[ch] == tx_vld_d2[ch])
      else begin
         err_cnt[ch][3]++;
         $display("FAILED t=%0t dac_valid_o[%0d] expected %b got %b", $time, ch,
                  $sampled(tx_vld_d2[ch]), $sampled(dac_valid_i[ch]));
      end

   end

   always_comb begin : totals
      value_errors_o = 0;
      valid_errors_o = 0;
      for (int ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin
         value_errors_o += err_cnt[ch][0] + err_cnt[ch][1];
         valid_errors_o += err_cnt[ch][2] + err_cnt[ch][3];
      end
   end

endmodule

/* verification/radio_frontend_tb.sv */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_frontend_tb
   import radio_setting_pkg::*, radio_sample_pkg::*;
();

   localparam logic [7:0] RX_OFF_I = 8'(`RX_FE_BASE + `FE_REG_OFFSET_I);
   localparam logic [7:0] RX_OFF_Q = 8'(`RX_FE_BASE + `FE_REG_OFFSET_Q);
   localparam logic [7:0] RX_MAP   = 8'(`RX_FE_BASE + `FE_REG_MAP);
   localparam logic [7:0] TX_OFF_I = 8'(`TX_FE_BASE + `FE_REG_OFFSET_I);
   localparam logic [7:0] TX_OFF_Q = 8'(`TX_FE_BASE + `FE_REG_OFFSET_Q);
   localparam logic [7:0] TX_MUX   = 8'(`TX_FE_BASE + `FE_REG_MAP);
   localparam int         DRAIN_LIMIT = 20;   // Clocks allowed for a drain

   logic     radio_clk;
   logic     reset;
   set_bus_t set_bus   [`RADIO_NUM_CHAN];
   iq_word_u adc_word  [`RADIO_NUM_CHAN];
   logic     adc_valid [`RADIO_NUM_CHAN];
   iq_word_u tx_word   [`RADIO_NUM_CHAN];
   logic     tx_valid  [`RADIO_NUM_CHAN];
   iq_word_u rx_word   [`RADIO_NUM_CHAN];
   logic     rx_valid  [`RADIO_NUM_CHAN];
   iq_word_u dac_word  [`RADIO_NUM_CHAN];
   logic     dac_valid [`RADIO_NUM_CHAN];
   int       value_errors;
   int       valid_errors;
   int       timeouts = 0;
   int       sent_cnt = 0;   // Input valids driven
   int       seen_cnt = 0;   // Output valids observed

   initial begin : clock_gen
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;   // 40 ns period
   end

   radio_frontend_top radio_frontend_top_inst (
      .radio_clk   (radio_clk),
      .reset_i     (reset),
      .set_bus_i   (set_bus),
      .adc_word_i  (adc_word),
      .adc_valid_i (adc_valid),
      .rx_word_o   (rx_word),
      .rx_valid_o  (rx_valid),
      .tx_word_i   (tx_word),
      .tx_valid_i  (tx_valid),
      .dac_word_o  (dac_word),
      .dac_valid_o (dac_valid)
   );

   radio_frontend_checks checks_inst (
      .radio_clk      (radio_clk),
      .reset_i        (reset),
      .set_bus_i      (set_bus),
      .adc_word_i     (adc_word),
      .adc_valid_i    (adc_valid),
      .tx_word_i      (tx_word),
      .tx_valid_i     (tx_valid),
      .rx_word_i      (rx_word),
      .rx_valid_i     (rx_valid),
      .dac_word_i     (dac_word),
      .dac_valid_i    (dac_valid),
      .value_errors_o (value_errors),
      .valid_errors_o (valid_errors)
   );

   always @(posedge radio_clk) begin : count_outputs
      if (!reset) begin
         for (int ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin
            if (rx_valid[ch])
               seen_cnt++;
            if (dac_valid[ch])
               seen_cnt++;
         end
      end
   end

   ///////////////////////////////
   // Drive helpers
   ///////////////////////////////

   task automatic clear_strobes();
      for (int ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin
         set_bus[ch].stb <= 1'b0;
         adc_valid[ch]   <= 1'b0;
         tx_valid[ch]    <= 1'b0;
      end
   endtask

   task automatic write_reg(input int ch, input logic [7:0] addr, input logic [31:0] data);
      @(posedge radio_clk);
      clear_strobes();
      set_bus[ch] <= '{stb: 1'b1, addr: addr, data: data};   // One-clock strobe
   endtask

   task automatic send(input int ch, input logic [31:0] adc, input logic [31:0] tx);
      @(posedge radio_clk);
      clear_strobes();
      adc_word[ch].raw <= adc;
      adc_valid[ch]    <= 1'b1;
      tx_word[ch].raw  <= tx;
      tx_valid[ch]     <= 1'b1;
      sent_cnt += 2;
   endtask

   task automatic send_random_all();
      @(posedge radio_clk);
      clear_strobes();
      for (int ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin
         adc_word[ch].raw <= $urandom();
         adc_valid[ch]    <= 1'b1;
         tx_word[ch].raw  <= $urandom();
         tx_valid[ch]     <= 1'b1;
         sent_cnt += 2;
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge radio_clk);
         clear_strobes();
      end
   endtask

   // Every driven sample must come back out
   task automatic wait_drain(input string phase);
      int waited;
      @(posedge radio_clk);
      clear_strobes();
      waited = 0;
      while (seen_cnt != sent_cnt && waited < DRAIN_LIMIT) begin
         @(negedge radio_clk);
         waited++;
      end
      if (seen_cnt != sent_cnt) begin
         timeouts++;
         $display("Timeout in %s phase, %0d output valids seen of %0d driven",
                  phase, seen_cnt, sent_cnt);
      end
   endtask

   ///////////////////////////////
   // Test phases
   ///////////////////////////////

   task automatic rx_offset_saturation();
      write_reg(0, RX_OFF_I, 32'h0000_7000);
      write_reg(0, RX_OFF_Q, 32'h0000_9000);   // -28672
      send(0, 32'h7fff_8000, 32'h0);
      send(0, 32'h1000_f000, 32'h0);           // I clamps, Q lands on -32768
      repeat (6) send(0, $urandom(), $urandom());
      write_reg(0, RX_OFF_I, 32'h0000_8000);
      write_reg(0, RX_OFF_Q, 32'h0000_7fff);
      send(0, 32'h8000_7fff, 32'h0);
      send(0, 32'h7fff_8000, 32'h0);
      repeat (4) send(0, $urandom(), $urandom());
      write_reg(0, RX_OFF_I, 32'h0);
      write_reg(0, RX_OFF_Q, 32'h0);
      wait_drain("RX offset");
   endtask

   task automatic rx_mapping();
      for (int m = 1; m < 4; m++) begin         // Swap, invert, both
         write_reg(0, RX_MAP, 32'(m));
         send(0, 32'h1234_8000, 32'h0);         // Q at -32768
         send(0, 32'h8000_8001, 32'h0);
         send(0, 32'h0001_7fff, 32'h0);
         repeat (3) send(0, $urandom(), $urandom());
      end
      write_reg(0, RX_OFF_Q, 32'h0000_0100);    // Map and offset together
      send(0, 32'h8000_7fff, 32'h0);
      write_reg(0, RX_MAP, 32'h0);
      write_reg(0, RX_OFF_Q, 32'h0);
      wait_drain("RX mapping");
   endtask

   task automatic tx_offset_swap();
      write_reg(0, TX_OFF_I, 32'h0000_7fff);
      write_reg(0, TX_OFF_Q, 32'h0000_8000);
      send(0, 32'h0, 32'h4000_c000);            // Both halves clamp
      write_reg(0, TX_MUX, 32'h3);              // Invert bit has no effect here
      send(0, 32'h0, 32'h4000_c000);            // Clamped I in the Q half
      repeat (6) send(0, $urandom(), $urandom());
      write_reg(0, TX_OFF_I, 32'h0);
      write_reg(0, TX_OFF_Q, 32'h0);
      wait_drain("TX offset and swap");
   endtask

   task automatic address_decode();
      logic [7:0] stray [9];
      stray = '{8'd223, 8'd227, 8'd228, 8'd229, 8'd230, 8'd231, 8'd235, 8'd0, 8'd255};
      write_reg(0, RX_OFF_I, 32'h0000_0100);
      write_reg(0, TX_MUX, 32'h3);              // Would swap and invert RX if it leaked
      for (int k = 0; k < 9; k++) begin
         write_reg(0, stray[k], $urandom());
         write_reg(1, stray[k], $urandom());
      end
      repeat (6) send_random_all();             // Ch 1 must stay pass-through
      wait_drain("address decode");
   endtask

   task automatic back_to_back();
      write_reg(1, RX_OFF_I, 32'h0000_7f00);
      write_reg(1, RX_MAP, 32'h3);
      write_reg(1, TX_OFF_Q, 32'h0000_0123);
      write_reg(1, TX_MUX, 32'h1);
      repeat (16) send_random_all();            // Continuous valid
      for (int n = 0; n < 24; n++) begin
         if ($urandom_range(1, 0) != 0)
            send_random_all();
         else
            idle(1);
      end
      send(1, 32'h7000_8000, 32'h7000_8000);
      write_reg(1, RX_MAP, 32'h0);              // Lands between two samples
      send(1, 32'h7000_8000, 32'h7000_8000);
      write_reg(1, TX_MUX, 32'h0);
      send(1, 32'h7000_8000, 32'h7000_8000);
      wait_drain("back-to-back");
   endtask

   ///////////////////////////////
   // Main sequence
   ///////////////////////////////

   initial begin : stimulus
      void'($urandom(32'ha360));                // Seed once
      reset <= 1'b1;
      for (int ch = 0; ch < `RADIO_NUM_CHAN; ch++) begin
         set_bus[ch]   <= '0;
         adc_word[ch]  <= '0;
         adc_valid[ch] <= 1'b0;
         tx_word[ch]   <= '0;
         tx_valid[ch]  <= 1'b0;
      end
      repeat (10) @(posedge radio_clk);
      reset <= 1'b0;
      idle(3);                                  // Valids stay low after reset
      repeat (8) send_random_all();             // All registers still zero
      wait_drain("pass-through");
      rx_offset_saturation();
      rx_mapping();
      tx_offset_swap();
      address_decode();
      back_to_back();
      idle(3);
      $display("Errors: %0d value, %0d valid timing, %0d timeouts",
               value_errors, valid_errors, timeouts);
      if (value_errors == 0 && valid_errors == 0 && timeouts == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* src.f */
+incdir+source
source/radio_setting_pkg.sv
source/radio_sample_pkg.sv
source/rx_frontend.sv
source/tx_frontend.sv
source/radio_frontend_top.sv
verification/radio_frontend_checks.sv
verification/radio_frontend_tb.sv

/* Makefile */
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f src.f --top-module radio_frontend_tb \
		-o radio_frontend_sim
	./obj_dir/radio_frontend_sim | tee /dev/stderr | grep -x "test passed" > /dev/null

clean:
	rm -rf obj_dir
